// ==== flist.f ====
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/muldiv_ctrl.sv
hdl/muldiv_lane.sv
hdl/muldiv_wb_arb.sv
hdl/muldiv_top.sv
sim/muldiv_sva.sv
sim/muldiv_tb.sv

// ==== Makefile ====
# mul/div block simulation with Verilator

TOP := muldiv_tb
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

obj_dir/V$(TOP): flist.f $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/muldiv_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for muldiv_top with stimulus, reference model and scoreboard
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_tb;

    import muldiv_pkg::*;

    localparam int LANES = `MULDIV_LANES;
    localparam int N_CID = 1 << `MULDIV_CID_W;
    // directed, random, saturation, back-pressure, flush
    localparam int N_REQ = 8 * 16 + 200 + 3 * LANES + 1;
    localparam int LIMIT = N_REQ * 60 + 500;

    logic        clk;
    logic        rst_i;
    logic        req_valid_i;
    muldiv_req_t req_i;
    logic        flush_i;
    logic        stall_o;
    logic        wb_ready_i;
    logic        wb_valid_o;
    muldiv_wb_t  wb_o;

    integer                   seed;
    int                       cycles = 0;
    int                       issued;
    int                       consumed;
    logic [`MULDIV_CID_W-1:0] next_cid;
    bit                       ready_random;
    string                    test_name;
    logic [31:0]              corner [4] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};

    // expected entry and in-flight counts per commit id
    muldiv_wb_t exp_wb    [N_CID];
    string      exp_name  [N_CID];
    int         issue_cnt [N_CID];
    int         seen_cnt  [N_CID];

    muldiv_top i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .stall_o     (stall_o),
        .wb_ready_i  (wb_ready_i),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_wb(input string name, input muldiv_wb_t exp, input muldiv_wb_t act);
        if (act !== exp) begin
            report_failure($sformatf(
                "ERROR %s: expected data=%h rd=%0d cid=%0d, actual data=%h rd=%0d cid=%0d",
                name, exp.data, exp.rd, exp.cid, act.data, act.rd, act.cid));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // M-extension result straight from the ISA rules
    function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [31:0] res;
        int          ia;
        int          ib;
        logic        ovf;
        sa  = {{32{a[31]}}, a};
        sb  = {{32{b[31]}}, b};
        ua  = {32'b0, a};
        ub  = {32'b0, b};
        ia  = a;
        ib  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'd0: res = 32'(ua * ub);
            3'd1: res = 32'((sa * sb) >> 32);
            3'd2: res = 32'((sa * ub) >> 32);
            3'd3: res = 32'((ua * ub) >> 32);
            3'd4: res = (b == 0) ? 32'hffff_ffff : ovf ? a : 32'(ia / ib);
            3'd5: res = (b == 0) ? 32'hffff_ffff : a / b;
            3'd6: res = (b == 0) ? a : ovf ? 32'h0 : 32'(ia % ib);
            default: res = (b == 0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic drive_ready();
        if (ready_random) begin
            wb_ready_i = ($random(seed) & 3) != 0;
        end
    endtask

    // one-cycle strobe on a falling edge while the stall flag is low
    task automatic send_req(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                            input bit flush);
        muldiv_req_t req;
        muldiv_wb_t  exp;
        int          r;
        while (stall_o) begin
            drive_ready();
            @(negedge clk);
        end
        drive_ready();
        r        = $random(seed);
        req.op   = muldiv_op_u'(f3);
        req.a    = a;
        req.b    = b;
        req.rd   = r[`MULDIV_REG_AW-1:0];
        req.cid  = next_cid;
        next_cid = next_cid + 1'b1;
        if (!flush) begin
            if (issue_cnt[req.cid] != seen_cnt[req.cid]) begin
                report_failure($sformatf("commit id %0d reused while still in flight",
                                         req.cid));
            end
            exp.data           = ref_result(f3, a, b);
            exp.rd             = req.rd;
            exp.cid            = req.cid;
            exp_wb[req.cid]    = exp;
            exp_name[req.cid]  = test_name;
            issue_cnt[req.cid] = issue_cnt[req.cid] + 1;
            issued             = issued + 1;
        end
        req_valid_i = 1'b1;
        req_i       = req;
        flush_i     = flush;
        @(negedge clk);
        req_valid_i = 1'b0;
        flush_i     = 1'b0;
    endtask

    task automatic drain();
        while (issued != consumed) begin
            @(negedge clk);
        end
    endtask

    // one scoreboard check per consumed writeback
    always @(posedge clk) begin
        if (wb_valid_o && wb_ready_i) begin
            if (seen_cnt[wb_o.cid] == issue_cnt[wb_o.cid]) begin
                report_failure($sformatf("writeback for commit id %0d was not expected",
                                         wb_o.cid));
            end else begin
                check_wb(exp_name[wb_o.cid], exp_wb[wb_o.cid], wb_o);
                seen_cnt[wb_o.cid] = seen_cnt[wb_o.cid] + 1;
                consumed           = consumed + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            report_failure($sformatf("timeout after %0d cycles, %0d of %0d results written back",
                                     cycles, consumed, issued));
        end
    end

    initial begin
        muldiv_wb_t  held;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        int          r;
        logic [`MULDIV_CID_W-1:0] first_cid;
        seed         = 32'h4129_ff2e;
        rst_i        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        flush_i      = 1'b0;
        wb_ready_i   = 1'b1;
        next_cid     = '0;
        issued       = 0;
        consumed     = 0;
        ready_random = 1'b0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // quiet after reset until a request is made
        check_flag("reset wb_valid", 1'b0, wb_valid_o);
        check_flag("reset stall", 1'b0, stall_o);
        repeat (4) begin
            @(negedge clk);
            check_flag("idle wb_valid", 1'b0, wb_valid_o);
        end

        // every op against zero, one, minus one and the most negative value
        test_name = "directed";
        for (int f = 0; f < 8; f++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send_req(3'(f), corner[i], corner[j], 1'b0);
                end
            end
        end
        drain();

        // random ops with a random ready pattern
        test_name    = "random";
        ready_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            r  = $random(seed);
            f3 = r[2:0];
            a  = $random(seed);
            b  = $random(seed);
            r  = $random(seed);
            case (r & 7)
                0: b = 32'h0;
                1: b = 32'hffff_ffff;
                2: a = 32'h8000_0000;
                default: ;
            endcase
            send_req(f3, a, b, 1'b0);
        end
        ready_random = 1'b0;
        wb_ready_i   = 1'b1;
        drain();

        test_name = "saturation";
        for (int l = 0; l < LANES; l++) begin
            send_req(3'd0, 32'(l + 3), 32'd7, 1'b0);
        end
        check_flag("stall with all lanes busy", 1'b1, stall_o);
        while (consumed == issued - LANES) begin
            @(negedge clk);
        end
        check_flag("stall after first result", 1'b0, stall_o);
        drain();

        // one extra op so every lane ends up holding a result
        test_name  = "back-pressure";
        wb_ready_i = 1'b0;
        first_cid  = next_cid;
        for (int l = 0; l <= LANES; l++) begin
            send_req(3'd5, 32'(1000 + l), 32'd7, 1'b0);
        end
        // lane 0 finishes first and fills the empty output register
        held = exp_wb[first_cid];
        while (!(wb_valid_o && stall_o)) begin
            @(negedge clk);
        end
        repeat (40) begin
            @(negedge clk);
            check_wb("back-pressure hold", held, wb_o);
            check_flag("back-pressure valid", 1'b1, wb_valid_o);
        end
        check_flag("stall under back-pressure", 1'b1, stall_o);
        wb_ready_i = 1'b1;
        drain();

        test_name = "flush";
        for (int l = 0; l < LANES - 1; l++) begin
            send_req(3'd1, 32'hdead_0000 + 32'(l), 32'h55, 1'b0);
        end
        send_req(3'd6, 32'h1234, 32'h10, 1'b1);
        check_flag("stall after flushed request", 1'b0, stall_o);
        drain();
        // window in which a flushed op would have come out
        repeat (40) begin
            @(negedge clk);
            check_flag("no output after flush", 1'b0, wb_valid_o);
        end

        if (issued == consumed && consumed == N_REQ - 1) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure($sformatf("%0d of %0d results written back, %0d requests expected",
                                     consumed, issued, N_REQ - 1));
        end
    end

endmodule

// ==== sim/muldiv_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and reset assertions, bound into muldiv_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_sva (
    input logic                     clk,
    input logic                     rst_i,
    input logic                     req_valid_i,
    input logic                     stall_i,
    input logic                     wb_ready_i,
    input logic                     wb_valid_i,
    input muldiv_pkg::muldiv_wb_t   wb_i,
    input logic [`MULDIV_LANES-1:0] start_i,
    input logic [`MULDIV_LANES-1:0] grant_i,
    input logic [`MULDIV_LANES-1:0] pending_i
);

    // requester holds off while every lane is reserved
    a_no_req_on_stall: assert property (
        @(posedge clk) disable iff (rst_i) req_valid_i |-> !stall_i
    ) else $error("request strobed while the stall flag was high");

    // output register frozen under back-pressure
    a_wb_hold: assert property (
        @(posedge clk) disable iff (rst_i)
        (wb_valid_i && !wb_ready_i) |=> (wb_valid_i && $stable(wb_i))
    ) else $error("writeback output changed while waiting for ready");

    a_reset_state: assert property (
        @(posedge clk) rst_i |=> (!wb_valid_i && !stall_i && (start_i == '0)
                                  && (grant_i == '0) && (pending_i == '0))
    ) else $error("control outputs not cleared by reset");

endmodule

bind muldiv_top muldiv_sva i_sva (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .stall_i     (stall_o),
    .wb_ready_i  (wb_ready_i),
    .wb_valid_i  (wb_valid_o),
    .wb_i        (wb_o),
    .start_i     (start),
    .grant_i     (grant),
    .pending_i   (pending)
);

// ==== hdl/muldiv_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mul/div block: issue control, lanes, writeback arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_top (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                    flush_i,
    output logic                    stall_o,
    input  logic                    wb_ready_i,
    output logic                    wb_valid_o,
    output muldiv_pkg::muldiv_wb_t  wb_o
);

    import muldiv_pkg::*;

    localparam int LANES = `MULDIV_LANES;

    logic [LANES-1:0] start;
    logic [LANES-1:0] grant;
    logic [LANES-1:0] pending;
    muldiv_req_t      lane_req [LANES];
    muldiv_wb_t       lane_res [LANES];

    muldiv_ctrl i_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .release_i   (grant),
        .start_o     (start),
        .lane_req_o  (lane_req),
        .stall_o     (stall_o)
    );

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        muldiv_lane i_lane (
            .clk           (clk),
            .rst_i         (rst_i),
            .start_i       (start[g]),
            .req_i         (lane_req[g]),
            .grant_i       (grant[g]),
            .res_pending_o (pending[g]),
            .res_o         (lane_res[g])
        );
    end

    muldiv_wb_arb i_wb_arb (
        .clk        (clk),
        .rst_i      (rst_i),
        .pending_i  (pending),
        .lane_res_i (lane_res),
        .wb_ready_i (wb_ready_i),
        .grant_o    (grant),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== hdl/muldiv_wb_arb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-priority writeback arbiter with held output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_wb_arb (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [`MULDIV_LANES-1:0] pending_i,
    input  muldiv_pkg::muldiv_wb_t   lane_res_i [`MULDIV_LANES],
    input  logic                     wb_ready_i,
    output logic [`MULDIV_LANES-1:0] grant_o,
    output logic                     wb_valid_o,
    output muldiv_pkg::muldiv_wb_t   wb_o
);

    import muldiv_pkg::*;

    localparam int LANES = `MULDIV_LANES;

    logic [LANES-1:0] lowest;
    logic             can_load;
    muldiv_wb_t       pick_res;

    // output register empty or draining this cycle
    assign can_load = ~wb_valid_o | wb_ready_i;

    // lane 0 wins
    assign lowest   = pending_i & (~pending_i + 1'b1);

    // also frees the lane reservation in the controller
    assign grant_o  = can_load ? lowest : '0;

    always_comb begin
        pick_res = '0;
        for (int i = 0; i < LANES; i++) begin
            if (lowest[i]) begin
                pick_res = lane_res_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else if (can_load) begin
            wb_valid_o <= |pending_i;
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && |pending_i) begin
            wb_o <= pick_res;
        end
    end

endmodule

// ==== hdl/muldiv_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one iterative lane: shift-add multiply, restoring divide
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_lane (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  muldiv_pkg::muldiv_req_t req_i,
    input  logic                    grant_i,
    output logic                    res_pending_o,
    output muldiv_pkg::muldiv_wb_t  res_o
);

    import muldiv_pkg::*;

    localparam int XLEN  = `MULDIV_XLEN;
    localparam int CNT_W = $clog2(`MULDIV_STEPS + 1);
    localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(`MULDIV_STEPS);

    logic                      busy_q;
    logic [CNT_W-1:0]          cnt_q;
    muldiv_op_u                op_q;
    logic                      sign_a_q;
    logic                      sign_b_q;
    logic                      div_zero_q;
    logic [XLEN-1:0]           opnd_q;
    // {partial product | remainder, multiplier | quotient}
    logic [2*XLEN-1:0]         acc_q;
    logic [`MULDIV_REG_AW-1:0] rd_q;
    logic [`MULDIV_CID_W-1:0]  cid_q;

    logic                      sgn_a;
    logic                      sgn_b;
    logic [XLEN-1:0]           mag_a;
    logic [XLEN-1:0]           mag_b;
    logic [XLEN:0]             add_sum;
    logic [XLEN:0]             rem_shift;
    logic [XLEN:0]             rem_diff;
    logic [2*XLEN-1:0]         prod;
    logic [XLEN-1:0]           quo;
    logic [XLEN-1:0]           rem;
    logic [XLEN-1:0]           result;
    logic                      finish;

    // operand signedness from the selected view of funct3
    always_comb begin
        if (req_i.op.div.is_div) begin
            sgn_a = ~req_i.op.div.uns & req_i.a[XLEN-1];
            sgn_b = ~req_i.op.div.uns & req_i.b[XLEN-1];
        end else begin
            unique case (req_i.op.mul.kind)
                MUL_HIGH_SS: begin
                    sgn_a = req_i.a[XLEN-1];
                    sgn_b = req_i.b[XLEN-1];
                end
                MUL_HIGH_SU: begin
                    sgn_a = req_i.a[XLEN-1];
                    sgn_b = 1'b0;
                end
                // low half is the same either way
                MUL_LOW, MUL_HIGH_UU: begin
                    sgn_a = 1'b0;
                    sgn_b = 1'b0;
                end
            endcase
        end
    end

    assign mag_a = sgn_a ? -req_i.a : req_i.a;
    assign mag_b = sgn_b ? -req_i.b : req_i.b;

    // one multiply step adds into the upper half
    assign add_sum   = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, opnd_q} : '0);

    // one divide step: trial subtract of the shifted remainder
    assign rem_shift = acc_q[2*XLEN-1:XLEN-1];
    assign rem_diff  = rem_shift - {1'b0, opnd_q};

    // sign fix-up, divide by zero keeps the all-ones quotient
    assign prod = (sign_a_q ^ sign_b_q) ? -acc_q : acc_q;
    assign quo  = ((sign_a_q ^ sign_b_q) & ~div_zero_q) ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    assign rem  = sign_a_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    always_comb begin
        if (op_q.div.is_div) begin
            result = op_q.div.rem ? rem : quo;
        end else if (op_q.mul.kind == MUL_LOW) begin
            result = prod[XLEN-1:0];
        end else begin
            result = prod[2*XLEN-1:XLEN];
        end
    end

    assign finish = busy_q && (cnt_q == STEP_LAST);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q        <= 1'b0;
            cnt_q         <= '0;
            res_pending_o <= 1'b0;
        end else begin
            if (grant_i) begin
                res_pending_o <= 1'b0;
            end
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (finish) begin
                busy_q        <= 1'b0;
                res_pending_o <= 1'b1;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            op_q       <= req_i.op;
            sign_a_q   <= sgn_a;
            sign_b_q   <= sgn_b;
            div_zero_q <= req_i.op.div.is_div && (req_i.b == '0);
            opnd_q     <= req_i.op.div.is_div ? mag_b : mag_a;
            acc_q      <= {{XLEN{1'b0}}, req_i.op.div.is_div ? mag_a : mag_b};
            rd_q       <= req_i.rd;
            cid_q      <= req_i.cid;
        end else if (busy_q && !finish) begin
            if (!op_q.div.is_div) begin
                acc_q <= {add_sum, acc_q[XLEN-1:1]};
            end else if (!rem_diff[XLEN]) begin
                acc_q <= {rem_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
            end else begin
                acc_q <= {rem_shift[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
            end
        end
        // held until granted
        if (finish) begin
            res_o.data <= result;
            res_o.rd   <= rd_q;
            res_o.cid  <= cid_q;
        end
    end

endmodule

// ==== hdl/muldiv_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue control: lane reservation, start strobes, stall flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "muldiv_macros.svh"

module muldiv_ctrl (
    input  logic                     clk,
    input  logic                     rst_i,

    // request from dispatch
    input  logic                     req_valid_i,
    input  muldiv_pkg::muldiv_req_t  req_i,
    input  logic                     flush_i,

    // lane release from the writeback arbiter
    input  logic [`MULDIV_LANES-1:0] release_i,

    // lane issue
    output logic [`MULDIV_LANES-1:0] start_o,
    output muldiv_pkg::muldiv_req_t  lane_req_o [`MULDIV_LANES],

    output logic                     stall_o
);

    localparam int LANES = `MULDIV_LANES;

    // one bit per lane, set from issue until the result leaves
    logic [LANES-1:0] reserved_q;
    logic [LANES-1:0] free;
    logic [LANES-1:0] free_low;
    logic             issue;

    assign free     = ~reserved_q;

    // isolate lowest set bit of the free mask
    assign free_low = free & (~free + 1'b1);

    // no free lane left
    assign stall_o  = &reserved_q;

    // flush kills the request before it takes a lane
    assign issue    = req_valid_i & ~flush_i & ~stall_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reserved_q <= '0;
            start_o    <= '0;
        end else begin
            reserved_q <= (reserved_q & ~release_i) | (issue ? free_low : '0);
            start_o    <= issue ? free_low : '0;
        end
    end

    // request copy per lane, valid alongside its start strobe
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (issue && free_low[i]) begin
                lane_req_o[i] <= req_i;
            end
        end
    end

endmodule

// ==== hdl/muldiv_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operation union, request and writeback structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "muldiv_macros.svh"

package muldiv_pkg;

    // funct3[1:0] when funct3[2] is clear
    typedef enum logic [1:0] {
        MUL_LOW     = 2'b00,
        MUL_HIGH_SS = 2'b01,
        MUL_HIGH_SU = 2'b10,
        MUL_HIGH_UU = 2'b11
    } muldiv_mul_kind_e;

    typedef struct packed {
        logic             is_div;
        muldiv_mul_kind_e kind;
    } muldiv_mul_op_t;

    typedef struct packed {
        logic is_div;
        logic rem;
        logic uns;
    } muldiv_div_op_t;

    // funct3, read through the view that bit 2 picks
    typedef union packed {
        muldiv_mul_op_t mul;
        muldiv_div_op_t div;
    } muldiv_op_u;

    typedef struct packed {
        muldiv_op_u                 op;
        logic [`MULDIV_XLEN-1:0]    a;
        logic [`MULDIV_XLEN-1:0]    b;
        logic [`MULDIV_REG_AW-1:0]  rd;
        logic [`MULDIV_CID_W-1:0]   cid;
    } muldiv_req_t;

    typedef struct packed {
        logic [`MULDIV_XLEN-1:0]    data;
        logic [`MULDIV_REG_AW-1:0]  rd;
        logic [`MULDIV_CID_W-1:0]   cid;
    } muldiv_wb_t;

endpackage

// ==== hdl/muldiv_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, lane count and step count of the mul/div block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

`define MULDIV_XLEN   32
`define MULDIV_REG_AW 5
`define MULDIV_CID_W  4
// 1 to 4 lanes are supported
`define MULDIV_LANES  2
`define MULDIV_STEPS  32

`endif
